// File: verilog.f
verilog/emesh_pkg.sv
verilog/emmu_cfg_pkg.sv
verilog/emmu_table.sv
verilog/emmu_table_arbiter.sv
verilog/emmu_axil_slave.sv
verilog/emmu.sv
verilog/emmu_top.sv
sim/emmu_tb.sv

// File: Bender.yml
package:
  name: emmu

sources:
  # packages first, then the modules below the top
  - verilog/emesh_pkg.sv
  - verilog/emmu_cfg_pkg.sv
  - verilog/emmu_table.sv
  - verilog/emmu_table_arbiter.sv
  - verilog/emmu_axil_slave.sv
  - verilog/emmu.sv
  - verilog/emmu_top.sv
  - target: test
    files:
      - sim/emmu_tb.sv

// File: sim/emmu_tb.sv
/*
  testbench for emmu_top that programs the table over AXI4-Lite and streams packets
  every output packet and bus response is checked against a model of the table
*/
`default_nettype none

module emmu_tb
  import emesh_pkg::*;
  import emmu_cfg_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT_CYCLES = 20000;  // well above the length of the tests

  typedef struct packed {
    emesh_addr_hi_t hi;
    emesh_packet_t  pkt;
  } expect_t;

  logic           clk, reset;
  axil_addr_t     s_axil_awaddr, s_axil_araddr;
  axil_data_t     s_axil_wdata, s_axil_rdata;
  axil_strb_t     s_axil_wstrb;
  axil_resp_t     s_axil_bresp, s_axil_rresp;
  logic           s_axil_awvalid, s_axil_awready, s_axil_wvalid, s_axil_wready;
  logic           s_axil_bvalid, s_axil_bready, s_axil_arvalid, s_axil_arready;
  logic           s_axil_rvalid, s_axil_rready;
  logic           emesh_access_in, emmu_access_out;
  emesh_packet_t  emesh_packet_in, emmu_packet_out;
  emesh_addr_hi_t emmu_packet_hi_out;

  table_entry_t  model_table [TABLE_DEPTH];  // x until written
  logic          model_en;
  table_index_t  idx_pool [$];               // entries safe to translate through
  table_index_t  saved_pool [$];
  table_index_t  idx;
  emesh_packet_t pending [$];                // sent last cycle and due out now
  expect_t       expected;
  int            errors, writes_issued, reads_issued, wr_hs, rd_hs, cycle_count;

  emmu_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  task automatic compare_value(input string name, input logic [103:0] got,
                               input logic [103:0] exp);
    if (got !== exp) begin
      errors++;
      $display("error: %s is %h, expected %h", name, got, exp);
    end
  endtask

  // byte address of one table word {1, index, word, 00}
  function automatic axil_addr_t table_addr(input table_index_t i, input logic word);
    return {1'b1, i, word, 2'b00};
  endfunction

  // translated address is {entry[43:0], offset} with the low word back in the packet
  function automatic expect_t expected_output(input emesh_packet_t pkt);
    expect_t     e;
    logic [63:0] full;
    e.pkt = pkt;
    e.hi  = '0;
    if (model_en) begin
      full          = {model_table[pkt.dstaddr[31:20]][43:0], pkt.dstaddr[19:0]};
      e.pkt.dstaddr = full[31:0];
      e.hi          = full[63:32];
    end
    return e;
  endfunction

  function automatic emesh_packet_t random_packet(input logic from_pool);
    emesh_packet_t p;
    p.upper   = {$urandom, $urandom};
    p.dstaddr = $urandom;
    p.ctrl    = 8'($urandom);
    if (from_pool) begin
      p.dstaddr[31:20] = idx_pool[$urandom_range(idx_pool.size() - 1, 0)];
    end
    return p;
  endfunction

  task automatic drive_packets(input int count, input logic from_pool);
    for (int i = 0; i < count; i++) begin
      @(negedge clk);
      emesh_access_in = 1'b1;  // back to back
      emesh_packet_in = random_packet(from_pool);
    end
    @(negedge clk);
    emesh_access_in = 1'b0;
  endtask

  task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                            input axil_strb_t strb, input int hold);
    axil_resp_t exp_resp;
    exp_resp = (addr[15] || addr[15:2] == 14'd0) ? RESP_OKAY : RESP_SLVERR;
    @(negedge clk);
    s_axil_awaddr  = addr;
    s_axil_awvalid = 1'b1;
    s_axil_wdata   = data;
    s_axil_wstrb   = strb;
    s_axil_wvalid  = 1'b1;
    do @(posedge clk); while (!s_axil_awready);
    compare_value("s_axil_wready", s_axil_wready, 1'b1);
    // model follows the handshake and word 1 has only two byte lanes
    if (addr[15]) begin
      for (int b = 0; b < 4; b++) begin
        if (strb[b] && (!addr[2] || b < 2)) begin
          model_table[addr[14:3]][(addr[2] ? 32 : 0) + 8*b +: 8] = data[8*b +: 8];
        end
      end
    end else if (addr[15:2] == 14'd0 && strb[0]) begin
      model_en = data[0];
    end
    @(negedge clk);
    s_axil_awvalid = 1'b0;
    s_axil_wvalid  = 1'b0;
    do @(posedge clk); while (!s_axil_bvalid);
    repeat (hold) begin
      @(posedge clk);  // response held while bready is low
      compare_value("s_axil_bvalid", s_axil_bvalid, 1'b1);
      compare_value("s_axil_bresp", s_axil_bresp, exp_resp);
    end
    @(negedge clk);
    s_axil_bready = 1'b1;
    @(posedge clk);
    compare_value("s_axil_bvalid", s_axil_bvalid, 1'b1);
    compare_value("s_axil_bresp", s_axil_bresp, exp_resp);
    writes_issued++;
    @(negedge clk);
    s_axil_bready = 1'b0;
  endtask

  task automatic axil_read(input axil_addr_t addr, input int hold);
    table_entry_t ent;
    axil_data_t   exp_data;
    axil_resp_t   exp_resp;
    ent      = model_table[addr[14:3]];
    exp_data = addr[15] ? (addr[2] ? {16'h0000, ent[47:32]} : ent[31:0]) :
               (addr[15:2] == 14'd0) ? {31'd0, model_en} : 32'd0;
    exp_resp = (addr[15] || addr[15:2] == 14'd0) ? RESP_OKAY : RESP_SLVERR;
    @(negedge clk);
    s_axil_araddr  = addr;
    s_axil_arvalid = 1'b1;
    do @(posedge clk); while (!s_axil_arready);
    @(negedge clk);
    s_axil_arvalid = 1'b0;
    do @(posedge clk); while (!s_axil_rvalid);  // may wait out a packet burst
    for (int c = 0; c <= hold; c++) begin
      if (c > 0) @(posedge clk);
      compare_value("s_axil_rvalid", s_axil_rvalid, 1'b1);
      compare_value("s_axil_rdata", s_axil_rdata, exp_data);
      compare_value("s_axil_rresp", s_axil_rresp, exp_resp);
      compare_value("s_axil_arready", s_axil_arready, 1'b0);  // one read at a time
    end
    @(negedge clk);
    s_axil_rready = 1'b1;
    @(posedge clk);
    compare_value("s_axil_rdata", s_axil_rdata, exp_data);
    compare_value("s_axil_rresp", s_axil_rresp, exp_resp);
    reads_issued++;
    @(negedge clk);
    s_axil_rready = 1'b0;
  endtask

  // packet checker and response counter sample before the edge updates
  always @(posedge clk) begin
    if (!reset) begin
      if (pending.size() > 0) begin
        if (!emmu_access_out) begin
          errors++;
          $display("a packet sent last cycle did not come out on emmu_access_out");
          void'(pending.pop_front());
        end else begin
          expected = expected_output(pending.pop_front());
          compare_value("emmu_packet_out", emmu_packet_out, expected.pkt);
          compare_value("emmu_packet_hi_out", emmu_packet_hi_out, expected.hi);
        end
      end else if (emmu_access_out) begin
        errors++;
        $display("emmu_access_out was raised with no packet sent the cycle before");
      end
      if (emesh_access_in) pending.push_back(emesh_packet_in);
      if (s_axil_bvalid && s_axil_bready) wr_hs++;
      if (s_axil_rvalid && s_axil_rready) rd_hs++;
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles, errors %0d",
             TIMEOUT_CYCLES, errors);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'hdc2e_7e59));
    {s_axil_awaddr, s_axil_awvalid, s_axil_wdata, s_axil_wstrb, s_axil_wvalid} = '0;
    {s_axil_bready, s_axil_araddr, s_axil_arvalid, s_axil_rready} = '0;
    emesh_access_in = 1'b0;
    emesh_packet_in = '0;
    model_en        = 1'b0;
    reset           = 1'b1;
    repeat (4) @(negedge clk);
    reset = 1'b0;

    axil_read(CTRL_ADDR, 0);  // enable off after reset
    repeat (10) drive_packets($urandom_range(8, 1), 1'b0);

    for (int i = 0; i < 16; i++) begin
      idx = table_index_t'({i[3:0], 8'($urandom)});  // distinct upper nibble
      axil_write(table_addr(idx, 1'b0), $urandom, 4'hf, 0);
      axil_write(table_addr(idx, 1'b1), $urandom, 4'hf, 0);
      idx_pool.push_back(idx);
    end
    axil_write(CTRL_ADDR, 32'h1, 4'h1, 0);
    drive_packets(200, 1'b1);

    foreach (idx_pool[i]) begin
      axil_read(table_addr(idx_pool[i], 1'b0), 0);
      axil_read(table_addr(idx_pool[i], 1'b1), 0);  // upper half reads zero
    end
    axil_write(16'h0004, 32'h0, 4'hf, 0);  // unmapped so the enable stays set
    axil_write(16'h4000, $urandom, 4'hf, 0);
    axil_read(16'h0004, 0);
    axil_read(16'h7ffc, 0);
    axil_read(CTRL_ADDR, 0);

    fork
      drive_packets(200, 1'b1);
      begin
        repeat (3) @(negedge clk);  // reads start inside the burst
        for (int k = 0; k < 4; k++) begin
          axil_read(table_addr(idx_pool[$urandom_range(15, 0)], k[0]), 0);
        end
      end
    join

    idx = idx_pool[3];
    axil_write(table_addr(idx, 1'b0), $urandom, 4'b0101, 0);
    axil_write(table_addr(idx, 1'b1), $urandom, 4'b0010, 0);
    axil_write(table_addr(idx, 1'b1), $urandom, 4'b1100, 0);  // no lanes in word 1
    axil_read(table_addr(idx, 1'b0), 0);
    axil_read(table_addr(idx, 1'b1), 0);
    saved_pool = idx_pool;
    idx_pool.delete();
    idx_pool.push_back(idx);
    drive_packets(20, 1'b1);
    idx_pool = saved_pool;

    for (int i = 0; i < 8; i++) begin
      idx = idx_pool[$urandom_range(15, 0)];
      axil_write(table_addr(idx, i[0]), $urandom, 4'hf, $urandom_range(6, 1));
      axil_read(table_addr(idx, i[0]), $urandom_range(6, 1));
    end
    axil_read(CTRL_ADDR, $urandom_range(6, 1));
    axil_write(16'h0100, $urandom, 4'hf, $urandom_range(6, 1));

    repeat (2) @(posedge clk);
    compare_value("write response count", wr_hs, writes_issued);
    compare_value("read response count", rd_hs, reads_issued);
    $display("errors %0d, writes %0d, reads %0d", errors, wr_hs, rd_hs);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/emmu_top.sv
/*
  address translator top: AXI4-Lite config slave, table, read arbiter, lookup pipeline
  packets in to out in one cycle, config reads share the table port
*/
`default_nettype none

module emmu_top
  import emesh_pkg::*;
  import emmu_cfg_pkg::*;
(
  input  logic           clk,
  input  logic           reset,
  input  axil_addr_t     s_axil_awaddr,
  input  logic           s_axil_awvalid,
  output logic           s_axil_awready,
  input  axil_data_t     s_axil_wdata,
  input  axil_strb_t     s_axil_wstrb,
  input  logic           s_axil_wvalid,
  output logic           s_axil_wready,
  output axil_resp_t     s_axil_bresp,
  output logic           s_axil_bvalid,
  input  logic           s_axil_bready,
  input  axil_addr_t     s_axil_araddr,
  input  logic           s_axil_arvalid,
  output logic           s_axil_arready,
  output axil_data_t     s_axil_rdata,
  output axil_resp_t     s_axil_rresp,
  output logic           s_axil_rvalid,
  input  logic           s_axil_rready,
  input  logic           emesh_access_in,
  input  emesh_packet_t  emesh_packet_in,
  output logic           emmu_access_out,
  output emesh_packet_t  emmu_packet_out,
  output emesh_addr_hi_t emmu_packet_hi_out
);

  logic         mmu_en;
  logic         tbl_wr_en, cfg_grant, cfg_data_valid, rd_en;
  table_be_t    tbl_wr_be;
  table_index_t tbl_wr_index, rd_index;
  table_entry_t tbl_wr_data, tbl_rd_data;  // rd data shared by both peers
  table_req_t   cfg_req, lookup_req;

  emmu_axil_slave u_slave (
    .clk, .reset,
    .s_axil_awaddr, .s_axil_awvalid, .s_axil_awready,
    .s_axil_wdata, .s_axil_wstrb, .s_axil_wvalid, .s_axil_wready,
    .s_axil_bresp, .s_axil_bvalid, .s_axil_bready,
    .s_axil_araddr, .s_axil_arvalid, .s_axil_arready,
    .s_axil_rdata, .s_axil_rresp, .s_axil_rvalid, .s_axil_rready,
    .mmu_en, .tbl_wr_en, .tbl_wr_be, .tbl_wr_index, .tbl_wr_data,
    .cfg_req, .cfg_grant, .cfg_data_valid, .tbl_rd_data
  );

  emmu_table_arbiter u_arbiter (
    .clk, .reset, .lookup_req, .cfg_req,
    .cfg_grant, .cfg_data_valid, .rd_en, .rd_index
  );

  emmu_table u_table (
    .clk,
    .wr_en (tbl_wr_en), .wr_be (tbl_wr_be), .wr_index (tbl_wr_index), .wr_data (tbl_wr_data),
    .rd_en, .rd_index, .rd_data (tbl_rd_data)
  );

  emmu u_emmu (
    .clk, .reset, .mmu_en,
    .emesh_access_in, .emesh_packet_in,
    .lookup_req, .tbl_rd_data,
    .emmu_access_out, .emmu_packet_out, .emmu_packet_hi_out
  );

endmodule

`default_nettype wire

// File: verilog/emmu.sv
/*
  lookup pipeline of the address translator with one cycle latency and no back-pressure
  when enabled the address is {entry[43:0], dstaddr[19:0]} with its low word in the packet
  when disabled the packet passes unchanged and the high word is zero
*/
`default_nettype none

module emmu
  import emesh_pkg::*;
  import emmu_cfg_pkg::*;
(
  input  logic           clk,
  input  logic           reset,
  input  logic           mmu_en,            // from the control register
  // packet in
  input  logic           emesh_access_in,
  input  emesh_packet_t  emesh_packet_in,
  // table read through the arbiter
  output table_req_t     lookup_req,
  input  table_entry_t   tbl_rd_data,       // valid the cycle after the request
  // packet out
  output logic           emmu_access_out,
  output emesh_packet_t  emmu_packet_out,
  output emesh_addr_hi_t emmu_packet_hi_out
);

  emesh_packet_t  pkt_q;     // held alongside the table read
  emesh_offset_t  offset_q;
  emesh_addr_t    addr_lo;
  emesh_addr_hi_t addr_hi;

  // index is the top PAGE_BITS of the incoming address
  assign lookup_req = '{valid: emesh_access_in,
                        index: table_index_t'(emesh_packet_in.dstaddr[ADDR_BITS-1 -: PAGE_BITS])};

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      emmu_access_out <= 1'b0;
    end else begin
      emmu_access_out <= emesh_access_in;
    end
  end

  // payload loaded once per packet
  always_ff @(posedge clk) begin
    if (emesh_access_in) begin
      pkt_q <= emesh_packet_in;
    end
  end

  assign offset_q = pkt_q.dstaddr[OFFSET_BITS-1:0];

  // enable sampled here in the output cycle
  always_comb begin
    if (mmu_en) begin
      addr_lo = {tbl_rd_data[PAGE_BITS-1:0], offset_q};       // entry 11:0 + offset
      addr_hi = tbl_rd_data[XLATE_BITS-1 -: ADDR_BITS];       // entry 43:12
    end else begin
      addr_lo = pkt_q.dstaddr;  // passthrough
      addr_hi = '0;
    end
  end

  assign emmu_packet_out = '{upper: pkt_q.upper, dstaddr: addr_lo, ctrl: pkt_q.ctrl};
  assign emmu_packet_hi_out = addr_hi;

  // each accepted packet leaves one cycle later with its own payload
  access_latency: assert property (
    @(posedge clk) disable iff (reset)
    emesh_access_in |=> emmu_access_out
      && emmu_packet_out.upper == $past(emesh_packet_in.upper)
      && emmu_packet_out.ctrl == $past(emesh_packet_in.ctrl)
  ) else $error("packet did not leave emmu one cycle after it arrived");

endmodule

`default_nettype wire

// File: verilog/emmu_axil_slave.sv
/*
  AXI4-Lite slave for the translator: control register and table window
  writes land in the handshake cycle, table reads go through the arbiter
  one read and one write outstanding at a time
*/
`default_nettype none

module emmu_axil_slave
  import emmu_cfg_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  // write address / data / response
  input  axil_addr_t   s_axil_awaddr,
  input  logic         s_axil_awvalid,
  output logic         s_axil_awready,
  input  axil_data_t   s_axil_wdata,
  input  axil_strb_t   s_axil_wstrb,
  input  logic         s_axil_wvalid,
  output logic         s_axil_wready,
  output axil_resp_t   s_axil_bresp,
  output logic         s_axil_bvalid,
  input  logic         s_axil_bready,
  // read address / data
  input  axil_addr_t   s_axil_araddr,
  input  logic         s_axil_arvalid,
  output logic         s_axil_arready,
  output axil_data_t   s_axil_rdata,
  output axil_resp_t   s_axil_rresp,
  output logic         s_axil_rvalid,
  input  logic         s_axil_rready,
  // to the translator
  output logic         mmu_en,
  output logic         tbl_wr_en,
  output table_be_t    tbl_wr_be,
  output table_index_t tbl_wr_index,
  output table_entry_t tbl_wr_data,
  output table_req_t   cfg_req,
  input  logic         cfg_grant,
  input  logic         cfg_data_valid,
  input  table_entry_t tbl_rd_data
);

  localparam int HI_BITS = TABLE_ENTRY_BITS - AXIL_DATA_BITS;  // 16 bits in word 1

  axil_state_t  state;
  logic         wr_go, wr_tbl, wr_ctrl, wr_word;
  logic         rd_tbl, rd_ctrl, rd_word, rd_done;
  table_index_t rd_index;

  function automatic logic addr_is_table(input axil_addr_t a);
    return (a & TABLE_BASE) == TABLE_BASE;
  endfunction

  function automatic logic addr_is_ctrl(input axil_addr_t a);
    return a[AXIL_ADDR_BITS-1:2] == CTRL_ADDR[AXIL_ADDR_BITS-1:2];  // byte offset ignored
  endfunction

  // write: both channels present, no response still pending
  assign wr_go          = s_axil_awvalid & s_axil_wvalid & ~s_axil_bvalid;
  assign s_axil_awready = wr_go;
  assign s_axil_wready  = wr_go;
  assign wr_tbl         = addr_is_table(s_axil_awaddr);
  assign wr_ctrl        = addr_is_ctrl(s_axil_awaddr);
  assign wr_word        = s_axil_awaddr[WORD_SEL_BIT];

  assign tbl_wr_en    = wr_go & wr_tbl;
  assign tbl_wr_index = s_axil_awaddr[WORD_SEL_BIT+1 +: TABLE_INDEX_BITS];
  assign tbl_wr_data  = {s_axil_wdata[HI_BITS-1:0], s_axil_wdata};  // both halves, be picks
  assign tbl_wr_be    = !tbl_wr_en ? '0 :
                        wr_word    ? {s_axil_wstrb[1:0], 4'b0000} :
                                     {2'b00, s_axil_wstrb};

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      s_axil_bvalid <= 1'b0;
      mmu_en        <= 1'b0;
    end else begin
      if (wr_go) begin
        s_axil_bvalid <= 1'b1;
      end else if (s_axil_bready) begin
        s_axil_bvalid <= 1'b0;
      end
      if (wr_go && wr_ctrl && s_axil_wstrb[0]) begin
        mmu_en <= s_axil_wdata[0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_go) begin
      s_axil_bresp <= (wr_tbl || wr_ctrl) ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // read side
  assign s_axil_arready = (state == idle);
  assign s_axil_rvalid  = (state == respond);
  assign cfg_req        = '{valid: (state == wait_grant), index: rd_index};
  assign rd_done        = (state == wait_data) && (cfg_data_valid || !rd_tbl);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= idle;
    end else begin
      case (state)
        idle:       if (s_axil_arvalid) state <= addr_is_table(s_axil_araddr) ?
                                                 wait_grant : wait_data;
        wait_grant: if (cfg_grant) state <= wait_data;
        wait_data:  if (rd_done) state <= respond;
        respond:    if (s_axil_rready) state <= idle;
        default:    state <= idle;
      endcase
    end
  end

  // latched request and response payload
  always_ff @(posedge clk) begin
    if (s_axil_arvalid && s_axil_arready) begin
      rd_tbl   <= addr_is_table(s_axil_araddr);
      rd_ctrl  <= addr_is_ctrl(s_axil_araddr);
      rd_word  <= s_axil_araddr[WORD_SEL_BIT];
      rd_index <= s_axil_araddr[WORD_SEL_BIT+1 +: TABLE_INDEX_BITS];
    end
    if (rd_done) begin
      s_axil_rresp <= (rd_tbl || rd_ctrl) ? RESP_OKAY : RESP_SLVERR;
      if (rd_tbl) begin
        s_axil_rdata <= rd_word ? axil_data_t'(tbl_rd_data[TABLE_ENTRY_BITS-1:AXIL_DATA_BITS])
                                : tbl_rd_data[AXIL_DATA_BITS-1:0];
      end else if (rd_ctrl) begin
        s_axil_rdata <= axil_data_t'(mmu_en);
      end else begin
        s_axil_rdata <= '0;  // unmapped
      end
    end
  end

  rdata_stable: assert property (
    @(posedge clk) disable iff (reset)
    s_axil_rvalid && !s_axil_rready |=>
      s_axil_rvalid && $stable(s_axil_rdata) && $stable(s_axil_rresp)
  ) else $error("rdata changed while rvalid held");

endmodule

`default_nettype wire

// File: verilog/emmu_table_arbiter.sv
/*
  fixed priority arbiter for the single table read port
  lookups always win and a config read goes through on a cycle with no lookup
  cfg_data_valid marks the cycle in which the shared read bus holds config data
*/
`default_nettype none

module emmu_table_arbiter
  import emmu_cfg_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  table_req_t   lookup_req,      // from the lookup pipeline
  input  table_req_t   cfg_req,         // from the AXI4-Lite slave and held until grant
  output logic         cfg_grant,
  output logic         cfg_data_valid,  // one cycle after cfg_grant
  output logic         rd_en,
  output table_index_t rd_index
);

  // lookup drives the read port first
  assign rd_en     = lookup_req.valid | cfg_req.valid;
  assign rd_index  = lookup_req.valid ? lookup_req.index : cfg_req.index;
  assign cfg_grant = cfg_req.valid & ~lookup_req.valid;  // idle cycle only

  // table has one cycle of read latency
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cfg_data_valid <= 1'b0;
    end else begin
      cfg_data_valid <= cfg_grant;
    end
  end

  // config peer keeps its request steady until granted
  cfg_req_held: assert property (
    @(posedge clk) disable iff (reset)
    cfg_req.valid && !cfg_grant |=> cfg_req.valid && $stable(cfg_req.index)
  ) else $error("config read request dropped or changed before its grant");

  // pending config read must not starve
  cfg_not_starved: assert property (
    @(posedge clk) disable iff (reset)
    cfg_req.valid |-> ##[0:4096] cfg_grant
  ) else $error("config read not granted within 4096 cycles");

endmodule

`default_nettype wire

// File: verilog/emmu_table.sv
/*
  translation table, 4096 x 48 bits
  byte-enabled write port, registered read port with one cycle latency
  read and write of the same entry in one cycle returns the old contents
*/
`default_nettype none

module emmu_table
  import emmu_cfg_pkg::*;
(
  input  logic         clk,
  // write port, config side only
  input  logic         wr_en,
  input  table_be_t    wr_be,
  input  table_index_t wr_index,
  input  table_entry_t wr_data,
  // read port, shared through the arbiter
  input  logic         rd_en,
  input  table_index_t rd_index,
  output table_entry_t rd_data
);

  table_entry_t mem [TABLE_DEPTH];  // no reset, contents undefined at start

  // byte lanes written independently
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int b = 0; b < TABLE_BYTES; b++) begin
        if (wr_be[b]) begin
          mem[wr_index][8*b +: 8] <= wr_data[8*b +: 8];
        end
      end
    end
  end

  // registered read, holds last value while idle
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_index];  // nonblocking so same-cycle write is not seen
    end
  end

  // slave must keep the byte enables quiet between writes
  be_only_with_wr_en: assert property (
    @(posedge clk) !wr_en |-> (wr_be == '0)
  ) else $error("table byte enables raised without wr_en");

endmodule

`default_nettype wire

// File: verilog/emmu_cfg_pkg.sv
/*
  translation table geometry and AXI4-Lite register map of the address translator
  ctrl register at 0x0000, table window at 0x8000 with two words per entry
*/
`default_nettype none

package emmu_cfg_pkg;

  // table geometry
  localparam int TABLE_INDEX_BITS = 12;
  localparam int TABLE_DEPTH      = 1 << TABLE_INDEX_BITS;  // 4096 entries
  localparam int TABLE_ENTRY_BITS = 48;
  localparam int TABLE_BYTES      = TABLE_ENTRY_BITS / 8;
  localparam int XLATE_BITS       = 44;  // low entry bits used by translation

  // AXI4-Lite widths
  localparam int AXIL_ADDR_BITS = 16;
  localparam int AXIL_DATA_BITS = 32;
  localparam int AXIL_STRB_BITS = AXIL_DATA_BITS / 8;

  typedef logic [TABLE_INDEX_BITS-1:0] table_index_t;
  typedef logic [TABLE_ENTRY_BITS-1:0] table_entry_t;
  typedef logic [TABLE_BYTES-1:0]      table_be_t;
  typedef logic [AXIL_ADDR_BITS-1:0]   axil_addr_t;
  typedef logic [AXIL_DATA_BITS-1:0]   axil_data_t;
  typedef logic [AXIL_STRB_BITS-1:0]   axil_strb_t;
  typedef logic [1:0]                  axil_resp_t;

  // register map
  localparam axil_addr_t CTRL_ADDR     = 16'h0000;  // bit 0 = enable
  localparam axil_addr_t TABLE_BASE    = 16'h8000;  // bit 15 selects the table
  localparam int         WORD_SEL_BIT  = 2;         // 0 = bits 31:0, 1 = bits 47:32

  localparam axil_resp_t RESP_OKAY   = 2'b00;
  localparam axil_resp_t RESP_SLVERR = 2'b10;

  // read request one peer hands to the arbiter
  typedef struct packed {
    logic         valid;
    table_index_t index;
  } table_req_t;

  typedef enum logic [1:0] {
    idle,        // arready high
    wait_grant,  // table read pending at arbiter
    wait_data,   // entry or register value on its way
    respond      // rvalid high until rready
  } axil_state_t;

endpackage

`default_nettype wire

// File: verilog/emesh_pkg.sv
/*
  mesh packet format shared by the translator and its testbench
  104-bit packet, 32-bit destination address split into page index and offset
*/
`default_nettype none

package emesh_pkg;

  // address geometry
  localparam int ADDR_BITS   = 32;
  localparam int PAGE_BITS   = 12;  // table index, top of dstaddr
  localparam int OFFSET_BITS = 20;  // passes through untranslated

  // other packet fields
  localparam int UPPER_BITS = 64;   // data and srcaddr, untouched here
  localparam int CTRL_BITS  = 8;    // write flag, datamode, ctrlmode

  typedef logic [ADDR_BITS-1:0]   emesh_addr_t;     // dstaddr field
  typedef logic [ADDR_BITS-1:0]   emesh_addr_hi_t;  // upper word of 64-bit address
  typedef logic [OFFSET_BITS-1:0] emesh_offset_t;   // page offset

  // field order matches the wire format, msb first
  typedef struct packed {
    logic [UPPER_BITS-1:0] upper;    // bits 103:40
    emesh_addr_t           dstaddr;  // bits 39:8
    logic [CTRL_BITS-1:0]  ctrl;     // bits 7:0
  } emesh_packet_t;

endpackage

`default_nettype wire
